// File: tpu_data_pkg.sv
package tpu_data_pkg;

    localparam int ARRAY_N = 4;
    localparam int ACT_W   = 8;
    localparam int WGT_W   = 8;
    localparam int RES_W   = 20;   // Holds ARRAY_N products of 8 by 8 bits.

    typedef logic [ACT_W-1:0] act_t;
    typedef logic [WGT_W-1:0] wgt_t;
    typedef logic [RES_W-1:0] res_t;

    typedef act_t act_vec_t [ARRAY_N];
    typedef wgt_t wgt_vec_t [ARRAY_N];
    typedef res_t res_vec_t [ARRAY_N];

endpackage

// File: tpu_ctrl_pkg.sv
package tpu_ctrl_pkg;

    // From an accepted vector to its result strobe.
    localparam int ARRAY_LAT = 2 * tpu_data_pkg::ARRAY_N + 1;

    localparam int ROW_CNT_W  = $clog2(tpu_data_pkg::ARRAY_N + 1);
    localparam int INFLIGHT_W = $clog2(ARRAY_LAT + 1);

    typedef logic [ROW_CNT_W-1:0] row_cnt_t;

endpackage

// File: mac_cell.sv
module mac_cell
    import tpu_data_pkg::*;
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic load_i,
    input  logic sel_i,
    input  logic act_en_i,
    input  wgt_t wgt_i,
    input  act_t act_i,
    input  res_t psum_i,
    output res_t psum_o,
    output act_t act_o,
    output wgt_t wgt_o
);

    wgt_t w_q [2];
    act_t act_q;
    res_t prod;

    always_comb begin
        prod = res_t'(act_q) * res_t'(w_q[sel_i]);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            w_q    <= '{default: '0};
            act_q  <= '0;
            psum_o <= '0;
        end else begin
            if (load_i) begin
                w_q[!sel_i] <= wgt_i;   // Only the shadow is written.
            end
            if (act_en_i) begin
                act_q <= act_i;
            end
            psum_o <= prod + psum_i;
        end
    end

    assign act_o = act_q;
    assign wgt_o = w_q[!sel_i];   // Feeds the shadow of the cell above.

endmodule

// File: skew_line.sv
module skew_line
    import tpu_data_pkg::*;
#(
    parameter type lane_t  = act_t,
    parameter bit  REVERSE = 1'b0
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  lane_t lanes_i [ARRAY_N],
    output lane_t lanes_o [ARRAY_N]
);

    for (genvar k = 0; k < ARRAY_N; k++) begin : g_lane
        // The reverse line also forms the output register of the result vector,
        // so each of its lanes carries one stage more.
        localparam int DEPTH = REVERSE ? ARRAY_N - k : k;

        if (DEPTH == 0) begin : g_pass
            assign lanes_o[k] = lanes_i[k];
        end else begin : g_delay
            lane_t sr_q [DEPTH];

            always_ff @(posedge clk_i) begin
                if (rst_i) begin
                    sr_q <= '{default: '0};
                end else begin
                    sr_q[0] <= lanes_i[k];
                    for (int s = 1; s < DEPTH; s++) begin
                        sr_q[s] <= sr_q[s-1];
                    end
                end
            end

            assign lanes_o[k] = sr_q[DEPTH-1];
        end
    end

endmodule

// File: mac_grid.sv
module mac_grid
    import tpu_data_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     load_i,
    input  logic     sel_i,
    input  logic     act_en_i,
    input  wgt_vec_t wgt_row_i,
    input  act_vec_t act_vec_i,
    output res_vec_t row_sum_o
);

    wgt_t wgt_up  [ARRAY_N][ARRAY_N];   // Shadow weight leaving cell (i,j).
    act_t act_dn  [ARRAY_N][ARRAY_N];   // Activation leaving cell (i,j).
    res_t psum_rt [ARRAY_N][ARRAY_N];   // Partial sum leaving cell (i,j).

    logic [2*ARRAY_N-3:0] en_q;
    logic [2*ARRAY_N-2:0] en_d;

    // The enable follows the activation wavefront, so cell (i,j) gets it i+j cycles late.
    assign en_d = {en_q, act_en_i};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q <= '0;
        end else begin
            en_q <= en_d[2*ARRAY_N-3:0];
        end
    end

    for (genvar i = 0; i < ARRAY_N; i++) begin : g_row
        for (genvar j = 0; j < ARRAY_N; j++) begin : g_col
            wgt_t wgt_in;
            act_t act_in;
            res_t psum_in;

            assign wgt_in  = (i == ARRAY_N - 1) ? wgt_row_i[j] : wgt_up[(i + 1) % ARRAY_N][j];
            assign act_in  = (i == 0) ? act_vec_i[j] : act_dn[(i + ARRAY_N - 1) % ARRAY_N][j];
            assign psum_in = (j == 0) ? '0 : psum_rt[i][(j + ARRAY_N - 1) % ARRAY_N];

            mac_cell u_cell (
                .clk_i    (clk_i),
                .rst_i    (rst_i),
                .load_i   (load_i),
                .sel_i    (sel_i),
                .act_en_i (en_d[i+j]),
                .wgt_i    (wgt_in),
                .act_i    (act_in),
                .psum_i   (psum_in),
                .psum_o   (psum_rt[i][j]),
                .act_o    (act_dn[i][j]),
                .wgt_o    (wgt_up[i][j])
            );
        end

        assign row_sum_o[i] = psum_rt[i][ARRAY_N-1];
    end

endmodule

// File: tile_sequencer.sv
module tile_sequencer
    import tpu_data_pkg::*;
    import tpu_ctrl_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     w_valid_i,
    input  wgt_vec_t w_row_i,
    input  logic     swap_i,
    input  logic     act_valid_i,
    output logic     w_ready_o,
    output logic     act_ready_o,
    output logic     load_o,
    output wgt_vec_t wgt_row_o,
    output logic     sel_o,
    output logic     act_en_o,
    output logic     res_valid_o
);

    row_cnt_t              row_cnt_q;
    logic                  pending_q;
    logic                  sel_q;
    logic                  load_q;
    wgt_vec_t              wgt_row_q;
    logic [INFLIGHT_W-1:0] inflight_q;
    logic [ARRAY_LAT-1:0]  vld_sr_q;
    logic                  w_take;
    logic                  act_take;
    logic                  shadow_full;
    logic                  swap_go;

    assign shadow_full = (row_cnt_q == row_cnt_t'(ARRAY_N));
    assign w_ready_o   = !shadow_full;
    assign act_ready_o = !pending_q;   // No vector may straddle two tiles.
    assign w_take      = w_valid_i && w_ready_o;
    assign act_take    = act_valid_i && act_ready_o;
    assign swap_go     = pending_q && shadow_full && (inflight_q == '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            row_cnt_q <= '0;
            pending_q <= 1'b0;
            sel_q     <= 1'b0;
            load_q    <= 1'b0;
        end else begin
            if (swap_go) begin
                row_cnt_q <= '0;
            end else if (w_take) begin
                row_cnt_q <= row_cnt_q + row_cnt_t'(1);
            end
            pending_q <= swap_i || (pending_q && !swap_go);
            if (swap_go) begin
                sel_q <= !sel_q;
            end
            load_q <= w_take;
        end
    end

    // The last row reaches the shadow in the swap cycle itself, still under the old select.
    always_ff @(posedge clk_i) begin
        wgt_row_q <= w_row_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            inflight_q <= '0;
            vld_sr_q   <= '0;
        end else begin
            case ({act_take, res_valid_o})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
            vld_sr_q <= {vld_sr_q[ARRAY_LAT-2:0], act_take};
        end
    end

    assign load_o      = load_q;
    assign wgt_row_o   = wgt_row_q;
    assign sel_o       = sel_q;
    assign act_en_o    = act_take;
    assign res_valid_o = vld_sr_q[ARRAY_LAT-1];

endmodule

// File: tpu_array_top.sv
module tpu_array_top
    import tpu_data_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     w_valid_i,
    input  wgt_vec_t w_row_i,
    output logic     w_ready_o,
    input  logic     swap_i,
    input  logic     act_valid_i,
    input  act_vec_t act_vec_i,
    output logic     act_ready_o,
    output logic     res_valid_o,
    output res_vec_t res_vec_o
);

    logic     load;
    logic     sel;
    logic     act_en;
    wgt_vec_t wgt_row;
    act_vec_t act_skewed;
    res_vec_t row_sum;

    tile_sequencer u_seq (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .w_valid_i   (w_valid_i),
        .w_row_i     (w_row_i),
        .swap_i      (swap_i),
        .act_valid_i (act_valid_i),
        .w_ready_o   (w_ready_o),
        .act_ready_o (act_ready_o),
        .load_o      (load),
        .wgt_row_o   (wgt_row),
        .sel_o       (sel),
        .act_en_o    (act_en),
        .res_valid_o (res_valid_o)
    );

    skew_line #(
        .lane_t  (act_t),
        .REVERSE (1'b0)
    ) u_act_skew (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .lanes_i (act_vec_i),
        .lanes_o (act_skewed)
    );

    mac_grid u_grid (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .load_i    (load),
        .sel_i     (sel),
        .act_en_i  (act_en),
        .wgt_row_i (wgt_row),
        .act_vec_i (act_skewed),
        .row_sum_o (row_sum)
    );

    skew_line #(
        .lane_t  (res_t),
        .REVERSE (1'b1)
    ) u_res_deskew (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .lanes_i (row_sum),
        .lanes_o (res_vec_o)
    );

endmodule

// File: tb_tpu_array.sv
module tb_tpu_array
    import tpu_data_pkg::*;
    import tpu_ctrl_pkg::*;
();

    localparam int MAX_CYCLES = 4000;   // The six tests take a few hundred cycles.

    logic     clk_i = 1'b0;
    logic     rst_i;
    logic     w_valid_i;
    wgt_vec_t w_row_i;
    logic     w_ready_o;
    logic     swap_i;
    logic     act_valid_i;
    act_vec_t act_vec_i;
    logic     act_ready_o;
    logic     res_valid_o;
    res_vec_t res_vec_o;

    int seed         = 56752;
    int cycle        = 0;
    int errors       = 0;
    int errs_before  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    int active_w [ARRAY_N][ARRAY_N];   // Tile the reference model computes with.
    int shadow_w [ARRAY_N][ARRAY_N];
    int tile_buf [ARRAY_N][ARRAY_N];   // Next tile to be loaded, row 0 first.
    int m_rows;
    bit m_pending;
    int due_q [$];                     // Cycle of each expected result strobe.
    int exp_vals [$];                  // ARRAY_N expected lanes per accepted vector.

    tpu_array_top DUT (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .w_valid_i   (w_valid_i),
        .w_row_i     (w_row_i),
        .w_ready_o   (w_ready_o),
        .swap_i      (swap_i),
        .act_valid_i (act_valid_i),
        .act_vec_i   (act_vec_i),
        .act_ready_o (act_ready_o),
        .res_valid_o (res_valid_o),
        .res_vec_o   (res_vec_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic value_error(input string name, input int expected, input int actual);
        $display("ERROR at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        errors++;
    endtask

    // Reference model and checks, evaluated on the values held during each cycle.
    always @(posedge clk_i) begin
        bit due;
        bit go;
        int sum;
        if (rst_i) begin
            m_rows    = 0;
            m_pending = 1'b0;
            active_w  = '{default: 0};
            shadow_w  = '{default: 0};
            due_q.delete();
            exp_vals.delete();
        end else begin
            assert (w_ready_o == (m_rows != ARRAY_N))
                else value_error("w_ready_o", m_rows != ARRAY_N, w_ready_o);
            assert (act_ready_o == !m_pending)
                else value_error("act_ready_o", !m_pending, act_ready_o);
            due = (due_q.size() != 0) && (due_q[0] == cycle);
            assert (res_valid_o == due)
                else value_error("res_valid_o", due, res_valid_o);
            go = m_pending && (m_rows == ARRAY_N) && (due_q.size() == 0);
            if (due) begin
                for (int i = 0; i < ARRAY_N; i++) begin
                    assert (res_vec_o[i] == exp_vals[i])
                        else value_error($sformatf("res_vec_o[%0d]", i), exp_vals[i],
                                         res_vec_o[i]);
                end
                for (int i = 0; i < ARRAY_N; i++) begin
                    void'(exp_vals.pop_front());
                end
                void'(due_q.pop_front());
            end
            if (act_valid_i && !m_pending) begin
                for (int i = 0; i < ARRAY_N; i++) begin
                    sum = 0;
                    for (int j = 0; j < ARRAY_N; j++) begin
                        sum += active_w[i][j] * int'(act_vec_i[j]);
                    end
                    exp_vals.push_back(sum);
                end
                due_q.push_back(cycle + ARRAY_LAT);
            end
            if (w_valid_i && (m_rows != ARRAY_N)) begin
                for (int j = 0; j < ARRAY_N; j++) begin
                    shadow_w[m_rows][j] = int'(w_row_i[j]);
                end
                m_rows++;
            end
            if (go) begin
                active_w = shadow_w;
                m_rows   = 0;
            end
            m_pending = swap_i || (m_pending && !go);
        end
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic send_vectors(input int n, input bit max_val);
        for (int k = 0; k < n; k++) begin
            act_valid_i = 1'b1;
            for (int j = 0; j < ARRAY_N; j++) begin
                act_vec_i[j] = max_val ? act_t'(8'hFF) : act_t'($random(seed));
            end
            do begin
                @(posedge clk_i);
            end while (!act_ready_o);
            #1;
            act_valid_i = 1'b0;
        end
    endtask

    task automatic fill_tile(input int kind);
        for (int i = 0; i < ARRAY_N; i++) begin
            for (int j = 0; j < ARRAY_N; j++) begin
                case (kind)
                    0:       tile_buf[i][j] = (i == j) ? 1 : 0;
                    1:       tile_buf[i][j] = $random(seed) & 255;
                    default: tile_buf[i][j] = 255;
                endcase
            end
        end
    endtask

    task automatic load_rows(input int first, input int count);
        for (int r = first; r < first + count; r++) begin
            w_valid_i = 1'b1;
            for (int j = 0; j < ARRAY_N; j++) begin
                w_row_i[j] = wgt_t'(tile_buf[r][j]);
            end
            do begin
                @(posedge clk_i);
            end while (!w_ready_o);
            #1;
            w_valid_i = 1'b0;
        end
    endtask

    task automatic pulse_swap();
        swap_i = 1'b1;
        @(posedge clk_i);
        #1;
        swap_i = 1'b0;
    endtask

    task automatic drain_results();
        while (due_q.size() != 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == errs_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errs_before);
        end
        errs_before = errors;
    endtask

    initial begin
        rst_i       = 1'b1;
        w_valid_i   = 1'b0;
        w_row_i     = '{default: '0};
        swap_i      = 1'b0;
        act_valid_i = 1'b0;
        act_vec_i   = '{default: '0};
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        assert (w_ready_o) else value_error("w_ready_o", 1, w_ready_o);
        assert (act_ready_o) else value_error("act_ready_o", 1, act_ready_o);
        assert (!res_valid_o) else value_error("res_valid_o", 0, res_valid_o);
        send_vectors(1, 1'b0);   // The active tile still holds zeros.
        drain_results();
        report_test("reset state");

        fill_tile(0);
        load_rows(0, ARRAY_N);
        pulse_swap();
        send_vectors(8, 1'b0);
        drain_results();
        report_test("identity tile");

        fill_tile(1);
        load_rows(0, ARRAY_N);
        pulse_swap();
        send_vectors(16, 1'b0);
        drain_results();
        report_test("back-to-back vectors");

        fill_tile(1);
        fork
            send_vectors(16, 1'b0);
            begin
                load_rows(0, ARRAY_N);
                w_valid_i = 1'b1;   // A full shadow has to refuse this row.
                wait_cycles(4);
                w_valid_i = 1'b0;
                pulse_swap();
            end
        join
        drain_results();
        report_test("double buffering");

        fill_tile(1);
        send_vectors(3, 1'b0);
        load_rows(0, 2);
        pulse_swap();
        fork
            send_vectors(6, 1'b0);
            begin
                wait_cycles(12);
                load_rows(2, 2);
            end
        join
        drain_results();
        report_test("delayed swap");

        fill_tile(2);
        load_rows(0, ARRAY_N);
        pulse_swap();
        send_vectors(4, 1'b1);
        drain_results();
        report_test("maximum values");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tpu_array.f
tpu_data_pkg.sv
tpu_ctrl_pkg.sv
mac_cell.sv
skew_line.sv
mac_grid.sv
tile_sequencer.sv
tpu_array_top.sv
tb_tpu_array.sv

// File: Makefile
TOP   = tb_tpu_array
FLIST = tpu_array.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f $(FLIST) --top-module tpu_array_top

sim:
	verilator --binary --timing --assert -j 0 -f $(FLIST) --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -F "Simulation finished: PASS"

clean:
	rm -rf obj_dir
